// File: common/ldpc_msg_pkg.sv
// LDPC message format package
// Sign-magnitude message layout, check node degree and magnitude helpers
package ldpc_msg_pkg;

    // Number of variable-to-check messages per check node
    localparam int CNU_DEGREE = 8;

    // Default magnitude width and full message width
    localparam int MAG_WIDTH = 7;
    localparam int MSG_WIDTH = MAG_WIDTH + 1;

    typedef logic [MAG_WIDTH-1:0] mag_t;

    // Sign in the top bit, magnitude below it
    typedef struct packed {
        logic sign;
        mag_t magnitude;
    } msg_t;

    // Message 0 sits in the low bits
    typedef msg_t [CNU_DEGREE-1:0] msg_vec_t;

    // One-hot, one bit per input message
    typedef logic [CNU_DEGREE-1:0] location_t;

    // Subtract an offset from a magnitude, floored at zero
    function automatic int unsigned floor_sub(int unsigned value, int unsigned offset);
        return (value > offset) ? (value - offset) : 0;
    endfunction

    // Build a message from its sign and magnitude
    function automatic msg_t make_msg(logic sign, mag_t magnitude);
        msg_t msg;
        msg.sign = sign;
        msg.magnitude = magnitude;
        return msg;
    endfunction

endpackage

// File: common/ldpc_ctrl_pkg.sv
// LDPC check node control package
// Control state encoding and minimum tree latency
package ldpc_ctrl_pkg;

    // Clock edges from minimum tree input to valid result
    localparam int MIN_LATENCY = 3;

    // IDLE waits for start, PASS1 finds min1, PASS2 finds min2, EMIT drives outputs
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        PASS1 = 2'd1,
        PASS2 = 2'd2,
        EMIT  = 2'd3
    } cnu_state_t;

endpackage

// File: hw/ldpc_minimum.sv
// LDPC minimum tree
// Three-stage pipelined unsigned minimum of eight magnitudes with one-hot location
`timescale 1ns/1ps

module ldpc_minimum
    import ldpc_msg_pkg::*;
#(
    parameter int MAG_WIDTH = 7
) (
    input  logic                                 i_clock,
    input  logic                                 i_reset,
    input  logic [CNU_DEGREE-1:0][MAG_WIDTH-1:0] i_in_data,
    output logic [MAG_WIDTH-1:0]                 o_out_data,
    output location_t                            o_min_location
);

    // Stage 0 holds four pair minimums, stage 1 holds two quad minimums
    logic [3:0][MAG_WIDTH-1:0] stage0_min;
    logic [3:0][1:0]           stage0_loc;
    logic [1:0][MAG_WIDTH-1:0] stage1_min;
    logic [1:0][3:0]           stage1_loc;

    // The left (lower index) side wins only when strictly smaller,
    // so equal magnitudes resolve to the higher index
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            stage0_min     <= '0;
            stage0_loc     <= '0;
            stage1_min     <= '0;
            stage1_loc     <= '0;
            o_out_data     <= '0;
            o_min_location <= '0;
        end else begin
            // Level 1, pairs of inputs
            for (int p = 0; p < 4; p++) begin
                if (i_in_data[2*p] < i_in_data[2*p+1]) begin
                    stage0_min[p] <= i_in_data[2*p];
                    stage0_loc[p] <= 2'b01;
                end else begin
                    stage0_min[p] <= i_in_data[2*p+1];
                    stage0_loc[p] <= 2'b10;
                end
            end

            // Level 2, location widens to four bits
            for (int q = 0; q < 2; q++) begin
                if (stage0_min[2*q] < stage0_min[2*q+1]) begin
                    stage1_min[q] <= stage0_min[2*q];
                    stage1_loc[q] <= {2'b00, stage0_loc[2*q]};
                end else begin
                    stage1_min[q] <= stage0_min[2*q+1];
                    stage1_loc[q] <= {stage0_loc[2*q+1], 2'b00};
                end
            end

            // Level 3, final minimum and full one-hot location
            if (stage1_min[0] < stage1_min[1]) begin
                o_out_data     <= stage1_min[0];
                o_min_location <= {4'b0000, stage1_loc[0]};
            end else begin
                o_out_data     <= stage1_min[1];
                o_min_location <= {stage1_loc[1], 4'b0000};
            end
        end
    end

endmodule

// File: hw/ldpc_latency_timer.sv
// LDPC latency timer
// Down-counter that flags when a minimum pass has left the pipeline
`timescale 1ns/1ps

module ldpc_latency_timer
    import ldpc_ctrl_pkg::*;
(
    input  logic i_clock,
    input  logic i_reset,
    input  logic i_load,
    output logic o_expired
);

    localparam int COUNT_WIDTH = $clog2(MIN_LATENCY + 1);

    logic [COUNT_WIDTH-1:0] count;

    // Expired pulses on the edge where the count reaches zero
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            count     <= '0;
            o_expired <= 1'b0;
        end else if (i_load) begin
            count     <= COUNT_WIDTH'(MIN_LATENCY);
            o_expired <= 1'b0;
        end else if (count != '0) begin
            count     <= count - 1'b1;
            o_expired <= (count == COUNT_WIDTH'(1));
        end else begin
            o_expired <= 1'b0;
        end
    end

endmodule

// File: hw/ldpc_cnu_control.sv
// LDPC check node control
// FSM sequencing input capture, the two minimum passes and output
`timescale 1ns/1ps

module ldpc_cnu_control
    import ldpc_ctrl_pkg::*;
(
    input  logic i_clock,
    input  logic i_reset,
    input  logic i_start,
    input  logic i_timer_expired,
    output logic o_load_input,
    output logic o_mask_enable,
    output logic o_timer_load,
    output logic o_capture_min1,
    output logic o_capture_min2,
    output logic o_emit,
    output logic o_busy
);

    cnu_state_t state;
    cnu_state_t state_next;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (i_start) begin
                    state_next = PASS1;
                end
            end
            PASS1: begin
                if (i_timer_expired) begin
                    state_next = PASS2;
                end
            end
            PASS2: begin
                if (i_timer_expired) begin
                    state_next = EMIT;
                end
            end
            EMIT: begin
                state_next = IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    // Start is only taken in IDLE
    assign o_load_input = (state == IDLE) && i_start;

    // Pass boundaries, min1 is ready at the end of PASS1 and min2 at the end of PASS2
    assign o_capture_min1 = (state == PASS1) && i_timer_expired;
    assign o_capture_min2 = (state == PASS2) && i_timer_expired;

    // Timer restarts on entry to each pass
    assign o_timer_load = o_load_input || o_capture_min1;

    assign o_mask_enable = (state == PASS2);
    assign o_emit        = (state == EMIT);
    assign o_busy        = (state != IDLE);

endmodule

// File: hw/ldpc_cnu_input.sv
// LDPC check node input stage
// Message register, sign split and min1 masking for the second pass
`timescale 1ns/1ps

module ldpc_cnu_input
    import ldpc_msg_pkg::*;
#(
    parameter int MAG_WIDTH = 7
) (
    input  logic                                 i_clock,
    input  logic                                 i_reset,
    input  logic                                 i_load,
    input  logic                                 i_mask_enable,
    input  logic [CNU_DEGREE-1:0][MAG_WIDTH:0]   i_messages,
    input  location_t                            i_min1_location,
    output logic [CNU_DEGREE-1:0][MAG_WIDTH-1:0] o_magnitudes,
    output logic [CNU_DEGREE-1:0]                o_signs
);

    logic [CNU_DEGREE-1:0][MAG_WIDTH:0] message_q;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            message_q <= '0;
        end else if (i_load) begin
            message_q <= i_messages;
        end
    end

    // The location fed back from the tree still reflects pass 1 for the
    // first three masked cycles, which covers the whole pass 2 sample window
    always_comb begin
        for (int i = 0; i < CNU_DEGREE; i++) begin
            o_signs[i] = message_q[i][MAG_WIDTH];
            if (i_mask_enable && i_min1_location[i]) begin
                // All ones never beats a real min2
                o_magnitudes[i] = '1;
            end else begin
                o_magnitudes[i] = message_q[i][MAG_WIDTH-1:0];
            end
        end
    end

endmodule

// File: hw/ldpc_cnu_output.sv
// LDPC check node output stage
// Holds min1, min2, location and sign parity, forms the offset min-sum outputs
`timescale 1ns/1ps

module ldpc_cnu_output
    import ldpc_msg_pkg::*;
#(
    parameter int MAG_WIDTH = 7
) (
    input  logic                               i_clock,
    input  logic                               i_reset,
    input  logic                               i_capture_min1,
    input  logic                               i_capture_min2,
    input  logic                               i_emit,
    input  logic [MAG_WIDTH-1:0]               i_min_value,
    input  location_t                          i_min_location,
    input  logic [CNU_DEGREE-1:0]              i_signs,
    input  logic [MAG_WIDTH-1:0]               i_offset,
    output logic [CNU_DEGREE-1:0][MAG_WIDTH:0] o_messages,
    output logic [MAG_WIDTH-1:0]               o_min1,
    output logic [MAG_WIDTH-1:0]               o_min2,
    output location_t                          o_min1_location,
    output logic                               o_done
);

    logic [MAG_WIDTH-1:0]               min1_q;
    logic [MAG_WIDTH-1:0]               min2_q;
    location_t                          location_q;
    logic                               sign_parity;
    logic [CNU_DEGREE-1:0][MAG_WIDTH:0] message_next;

    always_ff @(posedge i_clock) begin
        if (i_capture_min1) begin
            min1_q     <= i_min_value;
            location_q <= i_min_location;
        end
        if (i_capture_min2) begin
            min2_q <= i_min_value;
        end
    end

    // Product of all input signs
    assign sign_parity = ^i_signs;

    // Each output excludes its own input, so the min1 position gets min2
    always_comb begin
        logic [MAG_WIDTH-1:0] selected;
        for (int i = 0; i < CNU_DEGREE; i++) begin
            selected = location_q[i] ? min2_q : min1_q;
            message_next[i] = {sign_parity ^ i_signs[i],
                               MAG_WIDTH'(floor_sub(selected, i_offset))};
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_messages      <= '0;
            o_min1          <= '0;
            o_min2          <= '0;
            o_min1_location <= '0;
            o_done          <= 1'b0;
        end else begin
            o_done <= i_emit;
            if (i_emit) begin
                o_messages      <= message_next;
                o_min1          <= min1_q;
                o_min2          <= min2_q;
                o_min1_location <= location_q;
            end
        end
    end

endmodule

// File: hw/ldpc_check_node.sv
// LDPC check node unit, degree 8, offset min-sum
// Returns eight check-to-variable messages a fixed 9 cycles after start
`timescale 1ns/1ps

module ldpc_check_node
    import ldpc_msg_pkg::*;
#(
    parameter int MAG_WIDTH = ldpc_msg_pkg::MAG_WIDTH
) (
    input  logic                               i_clock,
    input  logic                               i_reset,
    input  logic                               i_start,
    input  logic [CNU_DEGREE-1:0][MAG_WIDTH:0] i_messages,
    input  logic [MAG_WIDTH-1:0]               i_offset,
    output logic                               o_busy,
    output logic                               o_done,
    output logic [CNU_DEGREE-1:0][MAG_WIDTH:0] o_messages,
    output logic [MAG_WIDTH-1:0]               o_min1,
    output logic [MAG_WIDTH-1:0]               o_min2,
    output location_t                          o_min1_location
);

    logic                                 load_input;
    logic                                 mask_enable;
    logic                                 timer_load;
    logic                                 timer_expired;
    logic                                 capture_min1;
    logic                                 capture_min2;
    logic                                 emit;
    logic [CNU_DEGREE-1:0][MAG_WIDTH-1:0] magnitudes;
    logic [CNU_DEGREE-1:0]                signs;
    logic [MAG_WIDTH-1:0]                 min_value;
    location_t                            min_location;

    ldpc_cnu_control u_control (
        .i_clock         (i_clock),
        .i_reset         (i_reset),
        .i_start         (i_start),
        .i_timer_expired (timer_expired),
        .o_load_input    (load_input),
        .o_mask_enable   (mask_enable),
        .o_timer_load    (timer_load),
        .o_capture_min1  (capture_min1),
        .o_capture_min2  (capture_min2),
        .o_emit          (emit),
        .o_busy          (o_busy)
    );

    ldpc_latency_timer u_timer (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_load    (timer_load),
        .o_expired (timer_expired)
    );

    ldpc_cnu_input #(
        .MAG_WIDTH (MAG_WIDTH)
    ) u_input (
        .i_clock         (i_clock),
        .i_reset         (i_reset),
        .i_load          (load_input),
        .i_mask_enable   (mask_enable),
        .i_messages      (i_messages),
        .i_min1_location (min_location),
        .o_magnitudes    (magnitudes),
        .o_signs         (signs)
    );

    ldpc_minimum #(
        .MAG_WIDTH (MAG_WIDTH)
    ) u_minimum (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_in_data      (magnitudes),
        .o_out_data     (min_value),
        .o_min_location (min_location)
    );

    ldpc_cnu_output #(
        .MAG_WIDTH (MAG_WIDTH)
    ) u_output (
        .i_clock         (i_clock),
        .i_reset         (i_reset),
        .i_capture_min1  (capture_min1),
        .i_capture_min2  (capture_min2),
        .i_emit          (emit),
        .i_min_value     (min_value),
        .i_min_location  (min_location),
        .i_signs         (signs),
        .i_offset        (i_offset),
        .o_messages      (o_messages),
        .o_min1          (o_min1),
        .o_min2          (o_min2),
        .o_min1_location (o_min1_location),
        .o_done          (o_done)
    );

endmodule

// File: verif/ldpc_check_node_asserts.sv
// Check node output assertions
// Bound to the top level, covering the done pulse and the min1 result
`timescale 1ns/1ps

module ldpc_check_node_asserts
    import ldpc_msg_pkg::*;
#(
    parameter int MAG_WIDTH = 7
) (
    input logic                 i_clock,
    input logic                 i_reset,
    input logic                 i_busy,
    input logic                 i_done,
    input logic [MAG_WIDTH-1:0] i_min1,
    input logic [MAG_WIDTH-1:0] i_min2,
    input location_t            i_min1_location
);

    done_single_cycle: assert property (@(posedge i_clock) disable iff (i_reset)
        i_done |=> !i_done)
        else $error("o_done held for more than one cycle");

    min_order: assert property (@(posedge i_clock) disable iff (i_reset)
        i_done |-> (i_min1 <= i_min2))
        else $error("o_min1 above o_min2 at o_done");

    location_one_hot: assert property (@(posedge i_clock) disable iff (i_reset)
        i_done |-> $onehot(i_min1_location))
        else $error("o_min1_location not one-hot at o_done");

    // EMIT keeps busy high on the cycle before done
    done_after_busy: assert property (@(posedge i_clock) disable iff (i_reset)
        i_done |-> $past(i_busy))
        else $error("o_done without busy on the cycle before");

endmodule

bind ldpc_check_node ldpc_check_node_asserts #(
    .MAG_WIDTH (MAG_WIDTH)
) u_asserts (
    .i_clock         (i_clock),
    .i_reset         (i_reset),
    .i_busy          (o_busy),
    .i_done          (o_done),
    .i_min1          (o_min1),
    .i_min2          (o_min2),
    .i_min1_location (o_min1_location)
);

// File: verif/ldpc_check_node_tb.sv
// Check node testbench
// Directed and LFSR-driven updates compared against an offset min-sum model
`timescale 1ns/1ps

module ldpc_check_node_tb
    import ldpc_msg_pkg::*;
();

    localparam int RESET_CYCLES   = 16;
    localparam int DONE_LATENCY   = 9;
    localparam int RANDOM_UPDATES = 200;
    // Directed tests take 11 update slots, the busy test counts as two
    localparam int TIMEOUT_CYCLES = (11 + RANDOM_UPDATES) * 12 + RESET_CYCLES;

    logic        i_clock;
    logic        i_reset;
    logic        i_start;
    msg_vec_t    i_messages;
    mag_t        i_offset;
    logic        o_busy;
    logic        o_done;
    msg_vec_t    o_messages;
    mag_t        o_min1;
    mag_t        o_min2;
    location_t   o_min1_location;
    int unsigned cycle_count;
    logic [15:0] lfsr_state;

    ldpc_check_node #(.MAG_WIDTH(MAG_WIDTH)) uut (.*);

    initial begin
        i_clock = 1'b0;
        forever #2 i_clock = ~i_clock;
    end

    always @(posedge i_clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycle_count);
            $display("Regression failed");
            $fatal(1, "timeout");
        end
    end

    task automatic check_msg_vec(input string name, input msg_vec_t actual, input msg_vec_t expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, actual, expected);
            $display("Regression failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_mag(input string name, input mag_t actual, input mag_t expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, actual, expected);
            $display("Regression failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_location(input string name, input location_t actual,
                                  input location_t expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, actual, expected);
            $display("Regression failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_latency(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, actual, expected);
            $display("Regression failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    task automatic random_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    function automatic msg_vec_t pack_messages(input logic [CNU_DEGREE-1:0] signs,
                                               input logic [CNU_DEGREE-1:0][MAG_WIDTH-1:0] mags);
        msg_vec_t msgs;
        for (int i = 0; i < CNU_DEGREE; i++) begin
            msgs[i] = make_msg(signs[i], mags[i]);
        end
        return msgs;
    endfunction

    // Reference offset min-sum update
    task automatic model_update(input msg_vec_t msgs, input mag_t offset,
                                output msg_vec_t exp_msgs, output mag_t exp_min1,
                                output mag_t exp_min2, output location_t exp_loc);
        int   loc;
        logic parity;
        mag_t sel;
        loc = 0;
        exp_min1 = msgs[0].magnitude;
        // Equal magnitudes move the location to the later index
        for (int i = 1; i < CNU_DEGREE; i++) begin
            if (msgs[i].magnitude <= exp_min1) begin
                exp_min1 = msgs[i].magnitude;
                loc = i;
            end
        end
        exp_min2 = '1;
        parity = 1'b0;
        for (int i = 0; i < CNU_DEGREE; i++) begin
            if (i != loc && msgs[i].magnitude < exp_min2) begin
                exp_min2 = msgs[i].magnitude;
            end
            parity = parity ^ msgs[i].sign;
        end
        exp_loc = '0;
        exp_loc[loc] = 1'b1;
        for (int i = 0; i < CNU_DEGREE; i++) begin
            sel = (i == loc) ? exp_min2 : exp_min1;
            exp_msgs[i].sign      = parity ^ msgs[i].sign;
            exp_msgs[i].magnitude = (sel > offset) ? mag_t'(sel - offset) : '0;
        end
    endtask

    // Returns in the time step of the edge that samples the start pulse
    task automatic start_update(input msg_vec_t msgs, input mag_t offset);
        @(posedge i_clock);
        i_start    <= 1'b1;
        i_messages <= msgs;
        i_offset   <= offset;
        @(posedge i_clock);
        i_start <= 1'b0;
    endtask

    task automatic wait_done(output int edges);
        edges = 0;
        @(negedge i_clock);
        while (o_done !== 1'b1) begin
            @(negedge i_clock);
            edges++;
        end
    endtask

    task automatic check_outputs(input msg_vec_t msgs, input mag_t offset);
        msg_vec_t  exp_msgs;
        mag_t      exp_min1;
        mag_t      exp_min2;
        location_t exp_loc;
        model_update(msgs, offset, exp_msgs, exp_min1, exp_min2, exp_loc);
        check_mag("o_min1", o_min1, exp_min1);
        check_mag("o_min2", o_min2, exp_min2);
        check_location("o_min1_location", o_min1_location, exp_loc);
        check_msg_vec("o_messages", o_messages, exp_msgs);
    endtask

    task automatic run_update(input msg_vec_t msgs, input mag_t offset);
        int edges;
        start_update(msgs, offset);
        wait_done(edges);
        check_latency("o_done latency", edges, DONE_LATENCY);
        check_outputs(msgs, offset);
    endtask

    // Leftmost magnitude in each literal is message 7
    task automatic distinct_magnitudes();
        run_update(pack_messages(8'h00, {7'd40, 7'd12, 7'd55, 7'd3, 7'd90, 7'd27, 7'd8, 7'd61}), 7'd0);
        run_update(pack_messages(8'h00, {7'd1, 7'd99, 7'd2, 7'd127, 7'd64, 7'd33, 7'd17, 7'd5}), 7'd0);
    endtask

    task automatic tied_minimum();
        run_update(pack_messages(8'h00, {7'd30, 7'd5, 7'd44, 7'd18, 7'd9, 7'd71, 7'd5, 7'd12}), 7'd0);
        check_location("o_min1_location", o_min1_location, 8'h40);
        check_mag("o_min2", o_min2, 7'd5);
        run_update(pack_messages(8'h00, {8{7'd20}}), 7'd0);
        check_location("o_min1_location", o_min1_location, 8'h80);
        check_mag("o_min2", o_min2, 7'd20);
    endtask

    task automatic offset_floor();
        run_update(pack_messages(8'h3c, {7'd14, 7'd6, 7'd22, 7'd9, 7'd31, 7'd11, 7'd8, 7'd19}), 7'd100);
        run_update(pack_messages(8'h3c, {7'd14, 7'd6, 7'd22, 7'd9, 7'd31, 7'd11, 7'd8, 7'd19}), 7'd2);
    endtask

    task automatic sign_patterns();
        run_update(pack_messages(8'hff, {7'd50, 7'd3, 7'd77, 7'd21, 7'd64, 7'd13, 7'd90, 7'd42}), 7'd1);
        run_update(pack_messages(8'h10, {7'd50, 7'd3, 7'd77, 7'd21, 7'd64, 7'd13, 7'd90, 7'd42}), 7'd1);
        run_update(pack_messages(8'ha5, {7'd50, 7'd3, 7'd77, 7'd21, 7'd64, 7'd13, 7'd90, 7'd42}), 7'd1);
    endtask

    task automatic start_while_busy();
        msg_vec_t first;
        int       edges;
        first = pack_messages(8'h81, {7'd26, 7'd70, 7'd15, 7'd38, 7'd4, 7'd59, 7'd83, 7'd47});
        start_update(first, 7'd3);
        repeat (2) @(posedge i_clock);
        i_start    <= 1'b1;
        i_messages <= pack_messages(8'h7e, {8{7'd1}});
        @(posedge i_clock);
        i_start <= 1'b0;
        wait_done(edges);
        // The ignored pulse is sampled three edges after the start edge
        check_latency("o_done latency", edges, DONE_LATENCY - 3);
        check_outputs(first, 7'd3);
        repeat (12) begin
            @(negedge i_clock);
            if (o_done || o_busy) begin
                $display("A start pulse while busy began a second update");
                $display("Regression failed");
                $fatal(1, "start accepted while busy");
            end
        end
    endtask

    task automatic lfsr_updates();
        msg_vec_t    msgs;
        logic [31:0] bits;
        for (int n = 0; n < RANDOM_UPDATES; n++) begin
            for (int i = 0; i < CNU_DEGREE; i++) begin
                random_bits(MSG_WIDTH, bits);
                msgs[i] = msg_t'(bits[MSG_WIDTH-1:0]);
            end
            // Four offset bits keep most outputs above zero
            random_bits(4, bits);
            run_update(msgs, mag_t'(bits[3:0]));
        end
    endtask

    initial begin
        i_reset     = 1'b1;
        i_start     = 1'b0;
        i_messages  = '0;
        i_offset    = '0;
        cycle_count = 0;
        lfsr_state  = 16'd23;
        repeat (RESET_CYCLES) @(posedge i_clock);
        i_reset <= 1'b0;
        distinct_magnitudes();
        tied_minimum();
        offset_floor();
        sign_patterns();
        start_while_busy();
        lfsr_updates();
        $display("Regression passed");
        $finish;
    end

endmodule

// File: ldpc_check_node.f
common/ldpc_msg_pkg.sv
common/ldpc_ctrl_pkg.sv
hw/ldpc_minimum.sv
hw/ldpc_latency_timer.sv
hw/ldpc_cnu_control.sv
hw/ldpc_cnu_input.sv
hw/ldpc_cnu_output.sv
hw/ldpc_check_node.sv
verif/ldpc_check_node_asserts.sv
verif/ldpc_check_node_tb.sv

// File: Makefile
TOP := ldpc_check_node_tb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the regression"
	@echo "make clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f ldpc_check_node.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log
